//--- include/ppu_consts.svh
`ifndef PPU_CONSTS_SVH
`define PPU_CONSTS_SVH

// Line and frame timing in clock cycles and lines
`define PPU_H_TOTAL      456
`define PPU_V_TOTAL      154
`define PPU_V_ACTIVE     144
`define PPU_H_PIXELS     160
`define PPU_OAM_CYCLES   80   // Mode 2 length
`define PPU_XFER_CYCLES  168  // Mode 3 length
`define PPU_HS_START     76
`define PPU_HS_WIDTH     4

// Video memory offsets inside the 8 KiB window
`define PPU_VRAM_AW      13
`define PPU_MAP0_BASE    13'h1800
`define PPU_MAP1_BASE    13'h1C00
`define PPU_TILE0_BASE   13'h0800
`define PPU_TILE1_BASE   13'h0000

// CPU address map
`define PPU_IO_BASE      16'hFF40
`define PPU_IO_LAST      16'hFF4B
`define PPU_VRAM_BASE    16'h8000
`define PPU_VRAM_LAST    16'h9FFF

`define PPU_BGP_RESET    8'hFC

`endif

//--- design/ppu_pkg.sv
package ppu_pkg;

    // STAT mode field encoding
    typedef enum logic [1:0] {
        HBLANK = 2'd0,
        VBLANK = 2'd1,
        OAM    = 2'd2,
        XFER   = 2'd3
    } ppu_mode_e;

    // Background fetch steps of one cycle each
    typedef enum logic [3:0] {
        IDLE,
        TID_ADDR,
        TID_READ,
        D0_ADDR,
        D0_READ,
        D1_ADDR,
        D1_READ,
        WAIT,
        LOAD
    } fetch_state_e;

    // Low address byte of each register
    typedef enum logic [7:0] {
        REG_LCDC = 8'h40,
        REG_STAT = 8'h41,
        REG_SCY  = 8'h42,
        REG_SCX  = 8'h43,
        REG_LY   = 8'h44,
        REG_LYC  = 8'h45,
        REG_BGP  = 8'h47
    } ppu_reg_e;

    typedef logic [1:0] pixel_t; // Color index or shade

endpackage

//--- design/ppu_cfg_if.sv
`timescale 1ns/1ps

// Configuration levels from the register file
interface ppu_cfg_if;

    logic       lcd_en;     // LCDC bit 7
    logic       bg_en;      // LCDC bit 0
    logic       bg_map_sel; // LCDC bit 3
    logic       tile_sel;   // LCDC bit 4
    logic [7:0] scx;
    logic [7:0] scy;
    logic [7:0] bgp;

    modport regs (
        output lcd_en, bg_en, bg_map_sel, tile_sel, scx, scy, bgp
    );

    modport timing (input lcd_en);

    modport fetch (input bg_map_sel, tile_sel, scx, scy);

    modport pixel (input bg_en, bgp);

endinterface

//--- design/ppu_regs.sv
`timescale 1ns/1ps
`include "ppu_consts.svh"

module ppu_regs
    import ppu_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  logic [15:0]   a,
    input  logic [7:0]    d_wr,
    input  logic          wr,
    input  logic          rd,
    output logic [7:0]    d_rd,
    input  logic [7:0]    ly,
    input  ppu_mode_e     mode,
    input  logic [7:0]    vram_rdata,
    output logic          cpu_vram_we,
    output logic          int_vblank_req,
    output logic          int_lcdc_req,
    input  logic          int_vblank_ack,
    input  logic          int_lcdc_ack,
    ppu_cfg_if.regs       cfg
);

    logic [7:0] lcdc;
    logic [3:0] stat_en;   // STAT bits 6 to 3
    logic [7:0] scy;
    logic [7:0] scx;
    logic [7:0] lyc;
    logic [7:0] bgp;

    logic       addr_io;
    logic       addr_vram;
    logic       coin;
    logic [7:0] stat_val;
    logic [7:0] reg_rdata;
    logic [7:0] rd_q;
    logic       vram_pend; // Memory read in flight
    ppu_mode_e  prev_mode;
    logic       coin_q;
    logic       vblank_entry;
    logic       stat_set;

    assign addr_io   = (a >= `PPU_IO_BASE) && (a <= `PPU_IO_LAST);
    assign addr_vram = (a >= `PPU_VRAM_BASE) && (a <= `PPU_VRAM_LAST);
    assign coin      = (ly == lyc);
    assign stat_val  = {1'b1, stat_en, coin, mode};

    assign cpu_vram_we = wr && addr_vram; // Memory drops it during XFER

    assign cfg.lcd_en     = lcdc[7];
    assign cfg.tile_sel   = lcdc[4];
    assign cfg.bg_map_sel = lcdc[3];
    assign cfg.bg_en      = lcdc[0];
    assign cfg.scx        = scx;
    assign cfg.scy        = scy;
    assign cfg.bgp        = bgp;

    ////////////////////////////////////////////////////////////////////
    // Register writes
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            lcdc    <= 8'h00;
            stat_en <= 4'h0;
            scy     <= 8'h00;
            scx     <= 8'h00;
            lyc     <= 8'h00;
            bgp     <= `PPU_BGP_RESET;
        end
        else if (wr && addr_io)
        begin
            case (a[7:0])
                REG_LCDC: lcdc    <= d_wr;
                REG_STAT: stat_en <= d_wr[6:3]; // Mode and coincidence are read only
                REG_SCY:  scy     <= d_wr;
                REG_SCX:  scx     <= d_wr;
                REG_LYC:  lyc     <= d_wr;
                REG_BGP:  bgp     <= d_wr;
                default:  ;                     // LY and the rest ignore writes
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////
    // CPU reads
    ////////////////////////////////////////////////////////////////////

    always_comb
    begin
        reg_rdata = 8'hFF;
        if (addr_io)
        begin
            case (a[7:0])
                REG_LCDC: reg_rdata = lcdc;
                REG_STAT: reg_rdata = stat_val;
                REG_SCY:  reg_rdata = scy;
                REG_SCX:  reg_rdata = scx;
                REG_LY:   reg_rdata = ly;
                REG_LYC:  reg_rdata = lyc;
                REG_BGP:  reg_rdata = bgp;
                default:  reg_rdata = 8'hFF;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            vram_pend <= 1'b0;
        else
            vram_pend <= rd && addr_vram && (mode != XFER);
    end

    // Blocked memory reads land here as FF
    always_ff @(posedge clk)
    begin
        if (rd)
            rd_q <= reg_rdata;
        else if (vram_pend)
            rd_q <= vram_rdata; // Hold the memory byte until the next read
    end

    assign d_rd = vram_pend ? vram_rdata : rd_q;

    ////////////////////////////////////////////////////////////////////
    // Interrupt requests
    ////////////////////////////////////////////////////////////////////

    assign vblank_entry = (mode == VBLANK) && (prev_mode != VBLANK);

    assign stat_set = (stat_en[3] && coin && !coin_q)
                   || (stat_en[2] && (mode == OAM) && (prev_mode != OAM))
                   || (stat_en[1] && vblank_entry)
                   || (stat_en[0] && (mode == HBLANK) && (prev_mode != HBLANK));

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            prev_mode      <= HBLANK;
            coin_q         <= 1'b0;
            int_vblank_req <= 1'b0;
            int_lcdc_req   <= 1'b0;
        end
        else
        begin
            prev_mode <= mode;
            coin_q    <= coin;
            if (vblank_entry)
                int_vblank_req <= 1'b1; // Set beats a same-cycle ack
            else if (int_vblank_ack)
                int_vblank_req <= 1'b0;
            if (stat_set)
                int_lcdc_req <= 1'b1;
            else if (int_lcdc_ack)
                int_lcdc_req <= 1'b0;
        end
    end

endmodule

//--- design/ppu_timing.sv
`timescale 1ns/1ps
`include "ppu_consts.svh"

module ppu_timing
    import ppu_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    ppu_cfg_if.timing cfg,
    output logic [7:0] ly,
    output ppu_mode_e mode,
    output logic      hs,
    output logic      vs
);

    logic [8:0] h_cnt; // Cycle within the line

    always_ff @(posedge clk)
    begin
        if (rst || !cfg.lcd_en)
        begin
            h_cnt <= 9'd0;
            ly    <= 8'd0;
        end
        else if (h_cnt == `PPU_H_TOTAL - 1)
        begin
            h_cnt <= 9'd0;
            if (ly == `PPU_V_TOTAL - 1)
                ly <= 8'd0;
            else
                ly <= ly + 8'd1;
        end
        else
        begin
            h_cnt <= h_cnt + 9'd1;
        end
    end

    // Mode straight from the counters
    always_comb
    begin
        if (!cfg.lcd_en)
            mode = HBLANK;
        else if (ly >= `PPU_V_ACTIVE)
            mode = VBLANK;
        else if (h_cnt < `PPU_OAM_CYCLES)
            mode = OAM;
        else if (h_cnt < `PPU_OAM_CYCLES + `PPU_XFER_CYCLES)
            mode = XFER;
        else
            mode = HBLANK;
    end

    assign hs = cfg.lcd_en && (h_cnt >= `PPU_HS_START)
             && (h_cnt < `PPU_HS_START + `PPU_HS_WIDTH);
    assign vs = cfg.lcd_en && (ly == `PPU_V_TOTAL - 1); // Whole last line

endmodule

//--- design/ppu_fetcher.sv
`timescale 1ns/1ps
`include "ppu_consts.svh"

module ppu_fetcher
    import ppu_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    ppu_cfg_if.fetch                cfg,
    input  logic [7:0]              ly,
    input  ppu_mode_e               mode,
    output logic [`PPU_VRAM_AW-1:0] fetch_addr,
    input  logic [7:0]              vram_rdata,
    output logic                    load,
    output pixel_t [7:0]            row
);

    fetch_state_e          state;
    logic [4:0]            tile_cnt;  // Tiles loaded this line
    logic [7:0]            tile_id;
    logic [7:0]            data_lo;
    logic [7:0]            data_hi;
    logic [7:0]            bg_y;
    logic [4:0]            tile_col;
    logic [`PPU_VRAM_AW-1:0] map_base;
    logic [`PPU_VRAM_AW-1:0] tile_base;
    logic [`PPU_VRAM_AW-1:0] map_addr;
    logic [`PPU_VRAM_AW-1:0] data_addr;

    assign bg_y      = ly + cfg.scy;
    assign tile_col  = tile_cnt + cfg.scx[7:3]; // Wraps at 32 without fine scroll
    assign map_base  = cfg.bg_map_sel ? `PPU_MAP1_BASE : `PPU_MAP0_BASE;
    assign tile_base = cfg.tile_sel ? `PPU_TILE1_BASE : `PPU_TILE0_BASE;
    assign map_addr  = map_base + {3'b000, bg_y[7:3], tile_col};
    assign data_addr = tile_base + {1'b0, tile_id, bg_y[2:0], 1'b0}; // 16 B per tile

    // IDLE doubles as the address step of the first tile
    always_comb
    begin
        case (state)
            D0_ADDR: fetch_addr = data_addr;
            D1_ADDR: fetch_addr = data_addr + 13'd1;
            default: fetch_addr = map_addr;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst || mode != XFER)
        begin
            state    <= IDLE;
            tile_cnt <= 5'd0;
        end
        else
        begin
            case (state)
                IDLE:
                begin
                    if (tile_cnt == 5'd0)
                        state <= TID_READ;
                end
                TID_ADDR: state <= TID_READ;
                TID_READ: state <= D0_ADDR;
                D0_ADDR:  state <= D0_READ;
                D0_READ:  state <= D1_ADDR;
                D1_ADDR:  state <= D1_READ;
                D1_READ:  state <= WAIT;
                WAIT:     state <= LOAD;
                LOAD:
                begin
                    tile_cnt <= tile_cnt + 5'd1;
                    if (tile_cnt == 5'(`PPU_H_PIXELS / 8 - 1))
                        state <= IDLE; // Line done, wait for next XFER
                    else
                        state <= TID_ADDR;
                end
                default:  state <= IDLE;
            endcase
        end
    end

    // Read data arrives one cycle after its address
    always_ff @(posedge clk)
    begin
        if (state == TID_READ)
            tile_id <= vram_rdata;
        if (state == D0_READ)
            data_lo <= vram_rdata;
        if (state == D1_READ)
            data_hi <= vram_rdata;
    end

    assign load = (state == LOAD);

    always_comb
    begin
        for (int i = 0; i < 8; i++)
            row[i] = {data_hi[i], data_lo[i]}; // row[7] is leftmost
    end

endmodule

//--- design/ppu_pixel_fifo.sv
`timescale 1ns/1ps

module ppu_pixel_fifo
    import ppu_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    ppu_cfg_if.pixel     cfg,
    input  logic         load,
    input  pixel_t [7:0] row,
    output pixel_t       pixel,
    output logic         valid
);

    pixel_t [15:0] q;      // q[0] is the oldest
    pixel_t [15:0] q_next;
    logic   [4:0]  cnt;
    logic   [4:0]  base;
    logic          pop;
    pixel_t        idx;

    assign pop  = (cnt != 5'd0);
    assign base = cnt - 5'(pop);

    always_comb
    begin
        q_next = pop ? {2'b00, q[15:1]} : q;
        if (load)
        begin
            for (int i = 0; i < 8; i++)
                q_next[base[3:0] + 4'(i)] = row[7 - i]; // Leftmost pixel first
        end
    end

    always_ff @(posedge clk)
    begin
        q <= q_next;
        if (rst)
            cnt <= 5'd0;
        else
            cnt <= base + (load ? 5'd8 : 5'd0);
    end

    // BGP lookup
    assign idx   = cfg.bg_en ? q[0] : 2'd0;
    assign pixel = cfg.bgp[2 * idx +: 2];
    assign valid = pop;

endmodule

//--- design/ppu_vram.sv
`timescale 1ns/1ps
`include "ppu_consts.svh"

module ppu_vram
    import ppu_pkg::*;
(
    input  logic                    clk,
    input  ppu_mode_e               mode,
    input  logic [`PPU_VRAM_AW-1:0] cpu_addr,
    input  logic                    cpu_we,
    input  logic [7:0]              cpu_wdata,
    input  logic [`PPU_VRAM_AW-1:0] fetch_addr,
    output logic [7:0]              vram_rdata
);

    logic [7:0]              mem [0:(1 << `PPU_VRAM_AW) - 1];
    logic                    xfer;
    logic [`PPU_VRAM_AW-1:0] addr;

    // Fetcher owns the port during pixel transfer
    assign xfer = (mode == XFER);
    assign addr = xfer ? fetch_addr : cpu_addr;

    always_ff @(posedge clk)
    begin
        if (cpu_we && !xfer)
            mem[addr] <= cpu_wdata;
        vram_rdata <= mem[addr]; // Old data on a write cycle
    end

endmodule

//--- design/ppu_top.sv
`timescale 1ns/1ps
`include "ppu_consts.svh"

module ppu_top
    import ppu_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic [15:0] a,
    input  logic [7:0]  d_wr,
    input  logic        wr,
    input  logic        rd,
    output logic [7:0]  d_rd,
    output logic        int_vblank_req,
    output logic        int_lcdc_req,
    input  logic        int_vblank_ack,
    input  logic        int_lcdc_ack,
    output logic [1:0]  pixel,
    output logic        valid,
    output logic        hs,
    output logic        vs
);

    logic [7:0]              ly;
    ppu_mode_e               mode;
    logic [`PPU_VRAM_AW-1:0] fetch_addr;
    logic [7:0]              vram_rdata;
    logic                    cpu_vram_we;
    logic                    load;
    pixel_t [7:0]            row;

    ppu_cfg_if cfg_if ();

    ppu_regs regs_inst (
        .clk            (clk),
        .rst            (rst),
        .a              (a),
        .d_wr           (d_wr),
        .wr             (wr),
        .rd             (rd),
        .d_rd           (d_rd),
        .ly             (ly),
        .mode           (mode),
        .vram_rdata     (vram_rdata),
        .cpu_vram_we    (cpu_vram_we),
        .int_vblank_req (int_vblank_req),
        .int_lcdc_req   (int_lcdc_req),
        .int_vblank_ack (int_vblank_ack),
        .int_lcdc_ack   (int_lcdc_ack),
        .cfg            (cfg_if.regs)
    );

    ppu_timing timing_inst (
        .clk  (clk),
        .rst  (rst),
        .cfg  (cfg_if.timing),
        .ly   (ly),
        .mode (mode),
        .hs   (hs),
        .vs   (vs)
    );

    ppu_fetcher fetcher_inst (
        .clk        (clk),
        .rst        (rst),
        .cfg        (cfg_if.fetch),
        .ly         (ly),
        .mode       (mode),
        .fetch_addr (fetch_addr),
        .vram_rdata (vram_rdata),
        .load       (load),
        .row        (row)
    );

    ppu_pixel_fifo fifo_inst (
        .clk   (clk),
        .rst   (rst),
        .cfg   (cfg_if.pixel),
        .load  (load),
        .row   (row),
        .pixel (pixel),
        .valid (valid)
    );

    // CPU address and data go straight to the memory
    ppu_vram vram_inst (
        .clk        (clk),
        .mode       (mode),
        .cpu_addr   (a[`PPU_VRAM_AW-1:0]),
        .cpu_we     (cpu_vram_we),
        .cpu_wdata  (d_wr),
        .fetch_addr (fetch_addr),
        .vram_rdata (vram_rdata)
    );

endmodule

//--- verification/tb_clk_gen.sv
`timescale 1ns/1ps

// Free running testbench clock
module tb_clk_gen #(
    parameter int HALF_PERIOD = 5 // 10 ns period
) (
    output logic clk
);

    initial
    begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

endmodule

//--- verification/ppu_tb.sv
`timescale 1ns/1ps
`include "ppu_consts.svh"

module ppu_tb
    import ppu_pkg::*;
;

    localparam int FRAME   = `PPU_H_TOTAL * `PPU_V_TOTAL;
    localparam int SIG_VS     = 0;
    localparam int SIG_VALID  = 1;
    localparam int SIG_VBLANK = 2;
    localparam int SIG_LCDC   = 3;
    localparam logic [7:0] LCDC_ON = 8'h91; // Display on, tiles at 0000, background on

    logic        clk;
    logic        rst;
    logic [15:0] a;
    logic [7:0]  d_wr;
    logic        wr;
    logic        rd;
    logic [7:0]  d_rd;
    logic        int_vblank_req;
    logic        int_lcdc_req;
    logic        int_vblank_ack;
    logic        int_lcdc_ack;
    logic [1:0]  pixel;
    logic        valid;
    logic        hs;
    logic        vs;

    integer      seed;
    logic [7:0]  mem_model [0:(1 << `PPU_VRAM_AW) - 1]; // Mirror of video memory
    int          scx_m;
    int          scy_m;
    int          bgp_m;
    int          msel_m;
    int          tsel_m;
    int          bg_m;

    string       cur_test;
    int          test_checks;
    int          test_errs;
    int          test_count;
    int          total_checks;
    int          total_errs;

    tb_clk_gen clk_gen_inst (.clk(clk));

    ppu_top ppu_top_inst (
        .clk            (clk),
        .rst            (rst),
        .a              (a),
        .d_wr           (d_wr),
        .wr             (wr),
        .rd             (rd),
        .d_rd           (d_rd),
        .int_vblank_req (int_vblank_req),
        .int_lcdc_req   (int_lcdc_req),
        .int_vblank_ack (int_vblank_ack),
        .int_lcdc_ack   (int_lcdc_ack),
        .pixel          (pixel),
        .valid          (valid),
        .hs             (hs),
        .vs             (vs)
    );

    //////////////////////////////////////////////////////////////////////
    // Bus and bookkeeping helpers
    //////////////////////////////////////////////////////////////////////

    // Inputs change and outputs are sampled 1 ns after the edge
    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    function automatic logic [15:0] io_addr(input ppu_reg_e r);
        return {8'hFF, r};
    endfunction

    task automatic write_bus(input logic [15:0] addr, input logic [7:0] data);
        a    = addr;
        d_wr = data;
        wr   = 1'b1;
        tick();
        wr   = 1'b0;
    endtask

    task automatic read_bus(input logic [15:0] addr, output logic [7:0] data);
        a  = addr;
        rd = 1'b1;
        tick();
        rd   = 1'b0;
        data = d_rd; // Valid the cycle after the strobe
    endtask

    task automatic open_test(input string name);
        cur_test    = name;
        test_checks = 0;
        test_errs   = 0;
    endtask

    task automatic close_test();
        test_count++;
        $display("test %s: %0d compares, %0d mismatches", cur_test, test_checks, test_errs);
    endtask

    task automatic check(input string label, input int expected, input int actual);
        test_checks++;
        total_checks++;
        if (expected !== actual)
        begin
            $display("[ERROR] %s %s expected %0h actual %0h", cur_test, label, expected, actual);
            test_errs++;
            total_errs++;
        end
    endtask

    task automatic note_timeout(input string what, input int limit);
        $display("Timeout in %s: %s did not happen within %0d cycles", cur_test, what, limit);
        test_errs++;
        total_errs++;
    endtask

    function automatic logic probe(input int sel);
        case (sel)
            SIG_VS:     return vs;
            SIG_VALID:  return valid;
            SIG_VBLANK: return int_vblank_req;
            default:    return int_lcdc_req;
        endcase
    endfunction

    task automatic wait_rise(input int sel, input int limit, input string what, output bit ok);
        logic prev;
        prev = probe(sel);
        ok   = 1'b0;
        for (int n = 0; n < limit && !ok; n++)
        begin
            tick();
            if (probe(sel) && !prev)
                ok = 1'b1;
            prev = probe(sel);
        end
        if (!ok)
            note_timeout({what, " rising"}, limit);
    endtask

    task automatic acknowledge(input int sel);
        if (sel == SIG_VBLANK)
            int_vblank_ack = 1'b1;
        else
            int_lcdc_ack = 1'b1;
        tick();
        int_vblank_ack = 1'b0;
        int_lcdc_ack   = 1'b0;
    endtask

    // Shade of background pixel x on a given line, from the memory mirror
    function automatic int model_shade(input int line, input int x);
        int bg_y;
        int map_addr;
        int tile_id;
        int data_addr;
        int bit_pos;
        int lo;
        int hi;
        int idx;
        bg_y      = (line + scy_m) % 256;
        map_addr  = (msel_m != 0) ? 'h1C00 : 'h1800;
        map_addr  = map_addr + (bg_y / 8) * 32 + ((x / 8 + scx_m / 8) % 32);
        tile_id   = int'(mem_model[map_addr]);
        data_addr = ((tsel_m != 0) ? 'h0000 : 'h0800) + tile_id * 16 + (bg_y % 8) * 2;
        bit_pos   = 7 - (x % 8); // Bit 7 is the leftmost pixel
        lo        = (int'(mem_model[data_addr]) >> bit_pos) & 1;
        hi        = (int'(mem_model[data_addr + 1]) >> bit_pos) & 1;
        idx       = (bg_m != 0) ? hi * 2 + lo : 0;
        return (bgp_m >> (2 * idx)) & 3;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Tests
    //////////////////////////////////////////////////////////////////////

    task automatic registers_readback();
        ppu_reg_e    rw_list [4];
        logic [15:0] unmapped [5];
        logic [7:0]  v;
        logic [7:0]  got;
        open_test("registers");
        rw_list  = '{REG_SCY, REG_SCX, REG_LYC, REG_BGP};
        unmapped = '{16'hFF46, 16'hFF48, 16'hFF4B, 16'h1234, 16'hA000};
        read_bus(io_addr(REG_BGP), got);
        check("bgp after reset", int'(`PPU_BGP_RESET), int'(got));
        for (int i = 0; i < 4; i++)
        begin
            v = 8'($random(seed));
            write_bus(io_addr(rw_list[i]), v);
            read_bus(io_addr(rw_list[i]), got);
            check($sformatf("reg %02h", rw_list[i]), int'(v), int'(got));
        end
        write_bus(io_addr(REG_LY), 8'($random(seed)));
        read_bus(io_addr(REG_LY), got);
        check("ly write ignored", 0, int'(got)); // Display off keeps LY at 0
        for (int i = 0; i < 5; i++)
        begin
            read_bus(unmapped[i], got);
            check($sformatf("unmapped %04h", unmapped[i]), 'hFF, int'(got));
        end
        close_test();
    endtask

    task automatic vram_readback();
        logic [7:0] v;
        logic [7:0] got;
        open_test("vram_off");
        for (int i = 0; i < (1 << `PPU_VRAM_AW); i++)
        begin
            v = 8'($random(seed));
            write_bus(16'(`PPU_VRAM_BASE + i), v);
            mem_model[i] = v;
        end
        for (int i = 0; i < (1 << `PPU_VRAM_AW); i++)
        begin
            read_bus(16'(`PPU_VRAM_BASE + i), got);
            check($sformatf("addr %04h", i), int'(mem_model[i]), int'(got));
        end
        close_test();
    endtask

    task automatic frame_timing();
        bit   ok;
        bit   done;
        bit   seg_open;
        logic hs_prev;
        logic vs_prev;
        int   hs_cnt;
        int   seg;
        int   full;
        int   empty;
        int   vs_cyc;
        open_test("frame_timing");
        write_bus(io_addr(REG_LCDC), LCDC_ON);
        wait_rise(SIG_VS, 2 * FRAME, "vs", ok);
        if (ok)
        begin
            hs_prev  = hs;
            vs_prev  = 1'b1;
            hs_cnt   = 0;
            seg      = 0;
            full     = 0;
            empty    = 0;
            vs_cyc   = 1;
            seg_open = 1'b0;
            done     = 1'b0;
            for (int n = 0; n < FRAME + 10 && !done; n++)
            begin
                tick();
                if (vs && !vs_prev)
                    done = 1'b1;
                else
                begin
                    // Each hs pulse opens a new line segment
                    if (hs && !hs_prev)
                    begin
                        if (seg_open && seg == `PPU_H_PIXELS)
                            full++;
                        else if (seg_open && seg == 0)
                            empty++;
                        seg_open = 1'b1;
                        seg      = 0;
                        hs_cnt++;
                    end
                    if (valid)
                        seg++;
                    if (vs)
                        vs_cyc++;
                end
                hs_prev = hs;
                vs_prev = vs;
            end
            if (!done)
                note_timeout("second vs pulse", FRAME + 10);
            if (seg_open && seg == `PPU_H_PIXELS)
                full++;
            else if (seg_open && seg == 0)
                empty++;
            check("hs pulses", `PPU_V_TOTAL, hs_cnt);
            check("lines with 160 valid", `PPU_V_ACTIVE, full);
            check("lines without valid", `PPU_V_TOTAL - `PPU_V_ACTIVE, empty);
            check("vs cycles", `PPU_H_TOTAL, vs_cyc);
        end
        write_bus(io_addr(REG_LCDC), 8'h00);
        close_test();
    endtask

    task automatic pixel_output(input string name, input int bg, input int lines);
        bit   done;
        logic hs_prev;
        int   hs_cnt;
        int   px;
        int   limit;
        open_test(name);
        write_bus(io_addr(REG_LCDC), 8'h00);
        scx_m  = int'($random(seed) & 255);
        scy_m  = int'($random(seed) & 255);
        bgp_m  = int'($random(seed) & 255);
        msel_m = int'($random(seed) & 1);
        tsel_m = int'($random(seed) & 1);
        bg_m   = bg;
        write_bus(io_addr(REG_SCX), 8'(scx_m));
        write_bus(io_addr(REG_SCY), 8'(scy_m));
        write_bus(io_addr(REG_BGP), 8'(bgp_m));
        write_bus(io_addr(REG_LCDC), 8'(128 + tsel_m * 16 + msel_m * 8 + bg_m));
        hs_prev = hs;
        hs_cnt  = 0;
        px      = 0;
        done    = 1'b0;
        limit   = (lines + 2) * `PPU_H_TOTAL;
        for (int n = 0; n < limit && !done; n++)
        begin
            tick();
            if (hs && !hs_prev)
            begin
                if (hs_cnt == lines)
                    done = 1'b1;
                hs_cnt++;
                px = 0;
            end
            else if (valid && hs_cnt > 0)
            begin
                check($sformatf("line %0d x %0d", hs_cnt - 1, px),
                      model_shade(hs_cnt - 1, px), int'(pixel));
                px++;
            end
            hs_prev = hs;
        end
        if (!done)
            note_timeout($sformatf("hs pulse after line %0d", lines - 1), limit);
        write_bus(io_addr(REG_LCDC), 8'h00);
        close_test();
    endtask

    task automatic vram_blocking();
        bit          ok;
        int          addr;
        logic [7:0]  old;
        logic [7:0]  got;
        logic [15:0] cpu_addr;
        open_test("vram_block");
        addr     = int'($random(seed) & 32'h1FFF);
        cpu_addr = 16'(`PPU_VRAM_BASE + addr);
        old      = mem_model[addr];
        write_bus(io_addr(REG_LCDC), LCDC_ON);
        wait_rise(SIG_VALID, FRAME, "valid", ok);
        if (ok)
        begin
            read_bus(cpu_addr, got);
            check("read during transfer", 'hFF, int'(got));
            check("valid at write", 1, int'(valid));
            write_bus(cpu_addr, ~old); // Must be dropped
        end
        write_bus(io_addr(REG_LCDC), 8'h00);
        read_bus(cpu_addr, got);
        check("old byte kept", int'(old), int'(got));
        close_test();
    endtask

    task automatic vblank_interrupt();
        bit   ok;
        int   rises;
        logic prev;
        open_test("vblank_irq");
        write_bus(io_addr(REG_LCDC), 8'h00);
        acknowledge(SIG_VBLANK);
        check("cleared before enable", 0, int'(int_vblank_req));
        write_bus(io_addr(REG_LCDC), LCDC_ON);
        wait_rise(SIG_VBLANK, 2 * FRAME, "int_vblank_req", ok);
        if (ok)
        begin
            repeat (10) tick();
            check("held until ack", 1, int'(int_vblank_req));
            acknowledge(SIG_VBLANK);
            check("cleared by ack", 0, int'(int_vblank_req));
            // One frame plus half a line holds exactly one V-blank entry
            rises = 0;
            prev  = int_vblank_req;
            for (int n = 0; n < FRAME + `PPU_H_TOTAL / 2; n++)
            begin
                tick();
                if (int_vblank_req && !prev)
                    rises++;
                prev = int_vblank_req;
            end
            check("rises per frame", 1, rises);
            acknowledge(SIG_VBLANK);
            check("cleared by second ack", 0, int'(int_vblank_req));
        end
        write_bus(io_addr(REG_LCDC), 8'h00);
        close_test();
    endtask

    task automatic stat_interrupt();
        bit         ok;
        int         lyc;
        logic [7:0] got;
        open_test("stat_irq");
        write_bus(io_addr(REG_LCDC), 8'h00);
        write_bus(io_addr(REG_STAT), 8'h00);
        lyc = int'(($random(seed) & 32'h7FFFFFFF) % `PPU_V_ACTIVE);
        write_bus(io_addr(REG_LYC), 8'(lyc));
        acknowledge(SIG_LCDC);
        check("cleared before enable", 0, int'(int_lcdc_req));
        write_bus(io_addr(REG_STAT), 8'h40); // Coincidence source only
        write_bus(io_addr(REG_LCDC), LCDC_ON);
        wait_rise(SIG_LCDC, 2 * FRAME, "int_lcdc_req", ok);
        if (ok)
        begin
            read_bus(io_addr(REG_LY), got);
            check("ly at request", lyc, int'(got));
            acknowledge(SIG_LCDC);
            check("cleared by ack", 0, int'(int_lcdc_req));
        end
        write_bus(io_addr(REG_STAT), 8'h00);
        write_bus(io_addr(REG_LCDC), 8'h00);
        close_test();
    endtask

    //////////////////////////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////////////////////////

    initial
    begin
        seed           = 32'h4c01;
        rst            = 1'b1;
        a              = 16'h0000;
        d_wr           = 8'h00;
        wr             = 1'b0;
        rd             = 1'b0;
        int_vblank_ack = 1'b0;
        int_lcdc_ack   = 1'b0;
        test_count     = 0;
        total_checks   = 0;
        total_errs     = 0;
        tick();
        tick();
        rst = 1'b0;

        registers_readback();
        vram_readback();
        frame_timing();
        pixel_output("pixels_bg_on", 1, `PPU_V_ACTIVE);
        pixel_output("pixels_bg_off", 0, 4);
        vram_blocking();
        vblank_interrupt();
        stat_interrupt();

        $display("summary: %0d tests, %0d compares, %0d mismatches",
                 test_count, total_checks, total_errs);
        if (total_errs == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

//--- compile.f
+incdir+include
design/ppu_pkg.sv
design/ppu_cfg_if.sv
design/ppu_regs.sv
design/ppu_timing.sv
design/ppu_fetcher.sv
design/ppu_pixel_fifo.sv
design/ppu_vram.sv
design/ppu_top.sv
verification/tb_clk_gen.sv
verification/ppu_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f compile.f --top-module ppu_tb -o ppu_sim
out=$(./obj_dir/ppu_sim)
echo "$out"
if echo "$out" | grep -q "ALL CHECKS PASSED"; then
    exit 0
else
    exit 1
fi
